// File: bench/exu_assert.sv
`timescale 1ns/1ns

module exu_assert #(
  parameter int MUL_BITS_PER_CYCLE = 4
) (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   issue_i,
  input exu_pkg::exu_issue_t    issue_data_i,
  input exu_pkg::exu_redirect_t redirect_i,
  input logic                   flush_i,
  input exu_pkg::exu_csr_wr_t   csr_wr_i,
  input logic                   stall_i
);
  import exu_pkg::*;

  localparam int STALL_MAX = XLEN / MUL_BITS_PER_CYCLE + 1;

  int unsigned stall_run;   // consecutive stall cycles so far

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stall_run <= 0;
    end else if (stall_i) begin
      stall_run <= stall_run + 1;
    end else begin
      stall_run <= 0;
    end
  end

  stall_len_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_run <= STALL_MAX)
    else $error("stall held longer than %0d cycles", STALL_MAX);

  redirect_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    redirect_i.valid |-> (issue_i && flush_i))
    else $error("redirect without issue or flush");

  csr_class_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    csr_wr_i.valid |-> issue_data_i.exc_op[EXC_CSR])
    else $error("csr write outside the csr class");

endmodule

bind exu_top exu_assert #(
  .MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)
) exu_assert_inst (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .issue_i      (issue_i),
  .issue_data_i (issue_data_i),
  .redirect_i   (redirect_o),
  .flush_i      (flush_o),
  .csr_wr_i     (csr_wr_o),
  .stall_i      (stall_o)
);

// File: bench/exu_tb.sv
`timescale 1ns/1ns

module exu_tb;
  import exu_pkg::*;

  localparam int MUL_BITS   = 4;
  localparam int STEPS      = XLEN / MUL_BITS;
  localparam int NUM_INSTR  = 400;
  localparam int MAX_CYCLES = NUM_INSTR * (STEPS + 2) + 2000;  // 6000 at the default step

  typedef struct packed {
    logic          alu_chk;   // class gives a defined rd value
    xlen_t         alu_data;
    exu_csr_wr_t   csr_wr;
    exu_redirect_t redirect;
    logic          flush;
    exu_bpu_upd_t  bpu_upd;
  } exu_expect_t;

  logic          clk;
  logic          rst_n;
  logic          issue;
  exu_issue_t    issue_data;
  xlen_t         alu_data;
  reg_idx_t      rd;
  exu_csr_wr_t   csr_wr;
  exu_redirect_t redirect;
  logic          flush;
  exu_bpu_upd_t  bpu_upd;
  logic          stall;
  logic          stall_seen;   // stall level just before the last rising edge
  integer        seed;
  int            cycle_cnt;
  int            done_cnt;
  int            mul_cnt;

  exu_top #(
    .MUL_BITS_PER_CYCLE(MUL_BITS)
  ) exu_top_inst (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .issue_i      (issue),
    .issue_data_i (issue_data),
    .alu_data_o   (alu_data),
    .rd_o         (rd),
    .csr_wr_o     (csr_wr),
    .redirect_o   (redirect),
    .flush_o      (flush),
    .bpu_upd_o    (bpu_upd),
    .stall_o      (stall)
  );

  task automatic fail_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] want);
    assert (got === want) else begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
      fail_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic want);
    assert (got === want) else begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
      fail_run();
    end
  endtask

  // rv32i integer ops, mul keeps the low word
  function automatic xlen_t alu_calc(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_MUL:  return a * b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_cond(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ALU_BEQ:  return a == b;
      ALU_BNE:  return a != b;
      ALU_BLT:  return $signed(a) < $signed(b);
      ALU_BGE:  return $signed(a) >= $signed(b);
      ALU_BLTU: return a < b;
      ALU_BGEU: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic exu_expect_t exu_ref_model(exu_issue_t ins);
    exu_expect_t e;
    xlen_t       uimm;
    xlen_t       src;
    logic        is_jump;
    logic        taken;
    e       = '0;
    uimm    = {ins.imm[XLEN-1:12], 12'b0};
    src     = ins.csr_imm_valid ? {27'b0, ins.csr_imm} : ins.rs1;
    is_jump = ins.exc_op[EXC_JAL] | ins.exc_op[EXC_JALR] | ins.exc_op[EXC_BRANCH];
    taken   = ins.exc_op[EXC_JAL] | ins.exc_op[EXC_JALR]
            | (ins.exc_op[EXC_BRANCH] & branch_cond(ins.alu_op, ins.rs1, ins.rs2));

    e.alu_chk = 1'b1;
    if (ins.exc_op[EXC_OP]) begin
      e.alu_data = alu_calc(ins.alu_op, ins.rs1, ins.rs2);
    end else if (ins.exc_op[EXC_OPIMM] | ins.exc_op[EXC_LOAD] | ins.exc_op[EXC_STORE]) begin
      e.alu_data = alu_calc(ins.alu_op, ins.rs1, ins.imm);
    end else if (ins.exc_op[EXC_LUI]) begin
      e.alu_data = uimm;
    end else if (ins.exc_op[EXC_AUIPC]) begin
      e.alu_data = ins.pc + uimm;
    end else if (ins.exc_op[EXC_JAL] | ins.exc_op[EXC_JALR]) begin
      e.alu_data = ins.pc + 32'd4;   // link value
    end else if (ins.exc_op[EXC_CSR]) begin
      e.alu_data = ins.csr_rdata;
    end else begin
      e.alu_chk = 1'b0;              // branch or none
    end

    e.csr_wr.valid = ins.exc_op[EXC_CSR] && (ins.csr_op != CSR_NONE);
    e.csr_wr.addr  = ins.csr_addr;
    case (ins.csr_op)
      CSR_RW:  e.csr_wr.data = src;
      CSR_RS:  e.csr_wr.data = ins.csr_rdata | src;
      CSR_RC:  e.csr_wr.data = ins.csr_rdata & ~src;
      default: e.csr_wr.data = ins.csr_rdata;
    endcase

    e.bpu_upd.valid   = is_jump;
    e.bpu_upd.taken   = taken;
    e.bpu_upd.correct = (taken == ins.pdt_taken);
    e.bpu_upd.pc      = ins.pc;
    if (ins.exc_op[EXC_JAL]) e.bpu_upd.jump_type = JUMP_JAL;
    else if (ins.exc_op[EXC_JALR]) e.bpu_upd.jump_type = JUMP_JALR;
    else if (ins.exc_op[EXC_BRANCH]) e.bpu_upd.jump_type = JUMP_BRANCH;

    e.flush          = is_jump && !e.bpu_upd.correct;
    e.redirect.valid = e.flush;
    if (ins.pdt_taken && !taken) e.redirect.pc = ins.pc + 32'd4;
    else if (ins.exc_op[EXC_JALR]) e.redirect.pc = (ins.rs1 + ins.imm) & ~32'd1;
    else e.redirect.pc = ins.pc + ins.imm;
    return e;
  endfunction

  task automatic gen_instr(output exu_issue_t ins);
    int cls;
    ins        = '0;
    cls        = {$random(seed)} % EXC_W;
    ins.exc_op = EXC_W'(1) << cls;
    ins.pc     = $random(seed) & 32'hffff_fffc;
    ins.rs1    = $random(seed);
    ins.rs2    = ({$random(seed)} % 4 == 0) ? ins.rs1 : $random(seed);  // hits eq compares
    ins.imm    = $random(seed);
    ins.rd     = 5'($random(seed));
    ins.alu_op = ALU_ADD;
    if (ins.exc_op[EXC_OP]) begin
      if ({$random(seed)} % 4 == 0) ins.alu_op = ALU_MUL;
      else ins.alu_op = alu_op_t'(5'({$random(seed)} % 10));
    end else if (ins.exc_op[EXC_OPIMM]) begin
      ins.alu_op = alu_op_t'(5'({$random(seed)} % 10));
      if (ins.alu_op == ALU_SUB) ins.alu_op = ALU_ADD;   // no subi
    end else if (ins.exc_op[EXC_BRANCH]) begin
      ins.alu_op = alu_op_t'(5'(10 + {$random(seed)} % 6));
    end
    ins.csr_op        = csr_op_t'(2'($random(seed)));
    ins.csr_addr      = 12'($random(seed));
    ins.csr_rdata     = $random(seed);
    ins.csr_imm       = 5'($random(seed));
    ins.csr_imm_valid = 1'($random(seed));
    ins.pdt_taken     = 1'($random(seed));
    if (ins.exc_op[EXC_CSR] && ({$random(seed)} % 4 == 0)) begin
      ins.rs1     = '0;   // zero source for rs/rc
      ins.csr_imm = '0;
    end
  endtask

  task automatic check_idle();
    check_bit("csr_wr_o.valid", csr_wr.valid, 1'b0);
    check_bit("redirect_o.valid", redirect.valid, 1'b0);
    check_bit("flush_o", flush, 1'b0);
    check_bit("bpu_upd_o.valid", bpu_upd.valid, 1'b0);
    check_bit("stall_o", stall, 1'b0);
  endtask

  task automatic check_issued(exu_expect_t want);
    if (want.alu_chk) check_word("alu_data_o", alu_data, want.alu_data);
    check_word("rd_o", 32'(rd), 32'(issue_data.rd));
    check_bit("csr_wr_o.valid", csr_wr.valid, want.csr_wr.valid);
    if (want.csr_wr.valid) begin
      check_word("csr_wr_o.addr", 32'(csr_wr.addr), 32'(want.csr_wr.addr));
      check_word("csr_wr_o.data", csr_wr.data, want.csr_wr.data);
    end
    check_bit("redirect_o.valid", redirect.valid, want.redirect.valid);
    if (want.redirect.valid) check_word("redirect_o.pc", redirect.pc, want.redirect.pc);
    check_bit("flush_o", flush, want.flush);
    check_bit("bpu_upd_o.valid", bpu_upd.valid, want.bpu_upd.valid);
    if (want.bpu_upd.valid) begin
      check_bit("bpu_upd_o.taken", bpu_upd.taken, want.bpu_upd.taken);
      check_bit("bpu_upd_o.correct", bpu_upd.correct, want.bpu_upd.correct);
      check_word("bpu_upd_o.pc", bpu_upd.pc, want.bpu_upd.pc);
      check_word("bpu_upd_o.jump_type", 32'(bpu_upd.jump_type), 32'(want.bpu_upd.jump_type));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one sample per clock cycle, taken as the cycle closes
  always @(posedge clk) begin
    stall_seen <= stall;
  end

  initial begin
    exu_issue_t next_ins;
    int         issued;
    seed       = 32'hbc47;
    rst_n      = 1'b0;
    issue      = 1'b0;
    issue_data = '0;
    issued     = 0;
    repeat (2) @(negedge clk);
    rst_n <= 1'b1;
    while (issued < NUM_INSTR) begin
      @(negedge clk);
      if (!(issue && stall)) begin   // current instruction retires here
        // gap after a mul so the DONE cycle ends first
        if ((issue && issue_data.alu_op == ALU_MUL) || ({$random(seed)} % 8 == 0)) begin
          issue <= 1'b0;
        end else begin
          gen_instr(next_ins);
          issue      <= 1'b1;
          issue_data <= next_ins;
          issued++;
        end
      end
    end
    @(negedge clk);
    while (issue && stall) begin
      @(negedge clk);
    end
    issue <= 1'b0;
    repeat (4) @(negedge clk);
    if (done_cnt == NUM_INSTR && mul_cnt > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("run ended with %0d of %0d instructions checked and %0d mul",
               done_cnt, NUM_INSTR, mul_cnt);
      fail_run();
    end
  end

  initial begin
    exu_expect_t want;
    int          stall_cycles;
    done_cnt     = 0;
    mul_cnt      = 0;
    stall_cycles = 0;
    forever begin
      @(negedge clk);
      if (!issue) begin
        check_idle();
        stall_cycles = 0;
      end else begin
        if (stall_seen) stall_cycles++;   // includes the mul load cycle
        if (!stall) begin
          want = exu_ref_model(issue_data);
          check_issued(want);
          check_word("stall cycles", stall_cycles,
                     (issue_data.alu_op == ALU_MUL) ? STEPS + 1 : 0);
          if (issue_data.alu_op == ALU_MUL) mul_cnt++;
          stall_cycles = 0;
          done_cnt++;
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        fail_run();
      end
    end
  end

endmodule

// File: compile.f
source/exu_pkg.sv
source/exu_ctrl.sv
source/exu_operand_sel.sv
source/exu_alu.sv
source/exu_csr_exec.sv
source/exu_branch_resolve.sv
source/exu_top.sv
bench/exu_assert.sv
bench/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module exu_tb -f compile.f -o exu_tb_sim

./obj_dir/exu_tb_sim | tee sim.log

grep -qx '>>> PASS' sim.log
echo "simulation passed"

// File: source/exu_alu.sv
`timescale 1ns/1ns

module exu_alu #(
  parameter int MUL_BITS_PER_CYCLE = 4
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  exu_pkg::xlen_t   alu_a_i,
  input  exu_pkg::xlen_t   alu_b_i,
  input  exu_pkg::alu_op_t alu_op_i,
  input  logic             mul_load_i,
  input  logic             mul_step_i,
  input  logic             mul_done_i,
  output exu_pkg::xlen_t   result_o,
  output logic             cmp_true_o
);
  import exu_pkg::*;

  xlen_t       alu_res;
  logic        eq;
  logic        lt_s;
  logic        lt_u;
  logic [4:0]  shamt;
  xlen_t       prod_q;
  xlen_t       mcand_q;
  xlen_t       mplier_q;
  xlen_t       partial;

  assign shamt = alu_b_i[4:0];
  assign eq    = (alu_a_i == alu_b_i);
  assign lt_s  = ($signed(alu_a_i) < $signed(alu_b_i));
  assign lt_u  = (alu_a_i < alu_b_i);

  always_comb begin
    case (alu_op_i)
      ALU_BEQ:  cmp_true_o = eq;
      ALU_BNE:  cmp_true_o = ~eq;
      ALU_BLT:  cmp_true_o = lt_s;
      ALU_BGE:  cmp_true_o = ~lt_s;
      ALU_BLTU: cmp_true_o = lt_u;
      ALU_BGEU: cmp_true_o = ~lt_u;
      default:  cmp_true_o = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = alu_a_i + alu_b_i;
      ALU_SUB:  alu_res = alu_a_i - alu_b_i;
      ALU_SLL:  alu_res = alu_a_i << shamt;
      ALU_SLT:  alu_res = XLEN'(lt_s);
      ALU_SLTU: alu_res = XLEN'(lt_u);
      ALU_XOR:  alu_res = alu_a_i ^ alu_b_i;
      ALU_SRL:  alu_res = alu_a_i >> shamt;
      ALU_SRA:  alu_res = xlen_t'($signed(alu_a_i) >>> shamt);
      ALU_OR:   alu_res = alu_a_i | alu_b_i;
      ALU_AND:  alu_res = alu_a_i & alu_b_i;
      ALU_MUL:  alu_res = '0;              // product comes from the registers
      default:  alu_res = XLEN'(cmp_true_o); // branch compares
    endcase
  end

  // partial products for the low multiplier bits of this step
  always_comb begin
    partial = '0;
    for (int k = 0; k < MUL_BITS_PER_CYCLE; k++) begin
      if (mplier_q[k]) partial = partial + (mcand_q << k);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prod_q   <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
    end else if (mul_load_i) begin
      prod_q   <= '0;
      mcand_q  <= alu_a_i;
      mplier_q <= alu_b_i;
    end else if (mul_step_i) begin
      prod_q   <= prod_q + partial;
      mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
      mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
    end
  end

  assign result_o = mul_done_i ? prod_q : alu_res;

endmodule

// File: source/exu_branch_resolve.sv
`timescale 1ns/1ns

module exu_branch_resolve (
  input  logic                  issue_i,
  input  exu_pkg::exu_issue_t   issue_data_i,
  input  exu_pkg::jump_type_t   jump_type_i,
  input  logic                  cmp_true_i,
  output exu_pkg::exu_redirect_t redirect_o,
  output logic                  flush_o,
  output exu_pkg::exu_bpu_upd_t bpu_upd_o
);
  import exu_pkg::*;

  logic  is_jump;
  logic  is_jalr;
  logic  taken;
  logic  correct;
  logic  mispredict;
  xlen_t tgt_a;
  xlen_t tgt_b;
  xlen_t tgt_sum;
  xlen_t target;

  assign is_jump = (jump_type_i != JUMP_NONE);
  assign is_jalr = (jump_type_i == JUMP_JALR);

  assign taken = (jump_type_i == JUMP_JAL) | is_jalr
               | ((jump_type_i == JUMP_BRANCH) & cmp_true_i);
  assign correct = (taken == issue_data_i.pdt_taken);

  // predicted taken but falls through, go back to pc+4
  always_comb begin
    if (issue_data_i.pdt_taken & ~taken) begin
      tgt_a = issue_data_i.pc;
      tgt_b = XLEN'(4);
    end else begin
      tgt_a = is_jalr ? issue_data_i.rs1 : issue_data_i.pc;
      tgt_b = issue_data_i.imm;
    end
  end

  assign tgt_sum = tgt_a + tgt_b;

  always_comb begin
    target = tgt_sum;
    if (is_jalr & taken) target[0] = 1'b0;  // jalr clears lsb
  end

  assign mispredict = issue_i & is_jump & ~correct;

  assign redirect_o.valid = mispredict;
  assign redirect_o.pc    = target;
  assign flush_o          = mispredict;

  // predictor is updated on every issued jump
  assign bpu_upd_o.valid     = issue_i & is_jump;
  assign bpu_upd_o.taken     = taken;
  assign bpu_upd_o.correct   = correct;
  assign bpu_upd_o.pc        = issue_data_i.pc;
  assign bpu_upd_o.jump_type = jump_type_i;

endmodule

// File: source/exu_csr_exec.sv
`timescale 1ns/1ns

module exu_csr_exec (
  input  logic                 issue_i,
  input  exu_pkg::exu_issue_t  issue_data_i,
  output exu_pkg::exu_csr_wr_t csr_wr_o
);
  import exu_pkg::*;

  xlen_t src;
  xlen_t old_val;
  xlen_t new_val;
  logic  is_csr;

  assign is_csr  = issue_data_i.exc_op[EXC_CSR];
  assign old_val = issue_data_i.csr_rdata;

  // zimm is zero extended
  assign src = issue_data_i.csr_imm_valid ? XLEN'(issue_data_i.csr_imm)
                                          : issue_data_i.rs1;

  always_comb begin
    case (issue_data_i.csr_op)
      CSR_RW:  new_val = src;
      CSR_RS:  new_val = old_val | src;
      CSR_RC:  new_val = old_val & ~src;
      default: new_val = old_val;
    endcase
  end

  // rs/rc with zero source still write, value unchanged
  assign csr_wr_o.valid = issue_i & is_csr & (issue_data_i.csr_op != CSR_NONE);
  assign csr_wr_o.addr  = issue_data_i.csr_addr;
  assign csr_wr_o.data  = new_val;

endmodule

// File: source/exu_ctrl.sv
`timescale 1ns/1ns

module exu_ctrl #(
  parameter int MUL_BITS_PER_CYCLE = 4
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 issue_i,
  input  exu_pkg::exc_op_t     exc_op_i,
  input  exu_pkg::alu_op_t     alu_op_i,
  output exu_pkg::opnd_sel_t   opnd_sel_o,
  output exu_pkg::jump_type_t  jump_type_o,
  output logic                 mul_load_o,
  output logic                 mul_step_o,
  output logic                 mul_done_o,
  output logic                 stall_o
);
  import exu_pkg::*;

  localparam int STEPS = XLEN / MUL_BITS_PER_CYCLE;
  localparam int CNT_W = $clog2(STEPS);

  mul_state_t       state_q;
  mul_state_t       state_d;
  logic [CNT_W-1:0] step_cnt_q;
  logic             mul_req;
  logic             last_step;

  // operand pair per class
  always_comb begin
    opnd_sel_o = OPND_RS1_RS2;
    if (exc_op_i[EXC_OPIMM] | exc_op_i[EXC_LOAD] | exc_op_i[EXC_STORE]) begin
      opnd_sel_o = OPND_RS1_IMM;
    end else if (exc_op_i[EXC_JAL] | exc_op_i[EXC_JALR]) begin
      opnd_sel_o = OPND_PC_4;       // link value
    end else if (exc_op_i[EXC_AUIPC]) begin
      opnd_sel_o = OPND_PC_UIMM;
    end else if (exc_op_i[EXC_LUI]) begin
      opnd_sel_o = OPND_ZERO_UIMM;
    end else if (exc_op_i[EXC_CSR]) begin
      opnd_sel_o = OPND_ZERO_CSR;   // old csr value goes to rd
    end
  end

  always_comb begin
    jump_type_o = JUMP_NONE;
    if (exc_op_i[EXC_JAL]) begin
      jump_type_o = JUMP_JAL;
    end else if (exc_op_i[EXC_JALR]) begin
      jump_type_o = JUMP_JALR;
    end else if (exc_op_i[EXC_BRANCH]) begin
      jump_type_o = JUMP_BRANCH;
    end
  end

  assign mul_req   = issue_i & (alu_op_i == ALU_MUL);
  assign last_step = (step_cnt_q == CNT_W'(STEPS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      MUL_IDLE: if (mul_req) state_d = MUL_RUN;
      MUL_RUN:  if (last_step) state_d = MUL_DONE;
      default:  state_d = MUL_IDLE;   // done lasts one cycle
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= MUL_IDLE;
      step_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (mul_load_o) step_cnt_q <= '0;
      else if (mul_step_o) step_cnt_q <= step_cnt_q + 1'b1;
    end
  end

  assign mul_load_o = (state_q == MUL_IDLE) & mul_req;
  assign mul_step_o = (state_q == MUL_RUN);
  assign mul_done_o = (state_q == MUL_DONE);
  assign stall_o    = mul_load_o | mul_step_o;

endmodule

// File: source/exu_operand_sel.sv
`timescale 1ns/1ns

module exu_operand_sel (
  input  exu_pkg::exu_issue_t issue_data_i,
  input  exu_pkg::opnd_sel_t  opnd_sel_i,
  output exu_pkg::xlen_t      alu_a_o,
  output exu_pkg::xlen_t      alu_b_o
);
  import exu_pkg::*;

  xlen_t uimm;

  // lui/auipc immediate, low 12 bits cleared
  assign uimm = {issue_data_i.imm[XLEN-1:12], 12'b0};

  always_comb begin
    case (opnd_sel_i)
      OPND_RS1_IMM: begin
        alu_a_o = issue_data_i.rs1;
        alu_b_o = issue_data_i.imm;
      end
      OPND_PC_4: begin
        alu_a_o = issue_data_i.pc;
        alu_b_o = XLEN'(4);
      end
      OPND_PC_UIMM: begin
        alu_a_o = issue_data_i.pc;
        alu_b_o = uimm;
      end
      OPND_ZERO_UIMM: begin
        alu_a_o = '0;
        alu_b_o = uimm;
      end
      OPND_ZERO_CSR: begin
        alu_a_o = '0;
        alu_b_o = issue_data_i.csr_rdata;
      end
      default: begin   // rs1/rs2, also branches
        alu_a_o = issue_data_i.rs1;
        alu_b_o = issue_data_i.rs2;
      end
    endcase
  end

endmodule

// File: source/exu_pkg.sv
package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;

  // one-hot execute class, bit positions below
  localparam int EXC_W      = 11;
  localparam int EXC_NONE   = 0;
  localparam int EXC_AUIPC  = 1;
  localparam int EXC_LUI    = 2;
  localparam int EXC_JAL    = 3;
  localparam int EXC_JALR   = 4;
  localparam int EXC_LOAD   = 5;
  localparam int EXC_STORE  = 6;
  localparam int EXC_BRANCH = 7;
  localparam int EXC_OPIMM  = 8;
  localparam int EXC_OP     = 9;
  localparam int EXC_CSR    = 10;

  typedef logic [EXC_W-1:0] exc_op_t;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_MUL
  } alu_op_t;

  typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_t;

  typedef enum logic [2:0] {
    OPND_RS1_RS2, OPND_RS1_IMM, OPND_PC_4, OPND_PC_UIMM, OPND_ZERO_UIMM, OPND_ZERO_CSR
  } opnd_sel_t;

  // same encoding as the predictor side
  typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR, JUMP_BRANCH} jump_type_t;

  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_t;

  typedef struct packed {
    xlen_t      pc;
    xlen_t      rs1;
    xlen_t      rs2;
    xlen_t      imm;
    reg_idx_t   rd;
    exc_op_t    exc_op;
    alu_op_t    alu_op;
    csr_op_t    csr_op;
    csr_addr_t  csr_addr;
    xlen_t      csr_rdata;      // csr value read in ID
    logic [4:0] csr_imm;        // zimm
    logic       csr_imm_valid;
    logic       pdt_taken;      // predicted direction
  } exu_issue_t;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
  } exu_redirect_t;

  typedef struct packed {
    logic       valid;
    logic       taken;
    logic       correct;
    xlen_t      pc;
    jump_type_t jump_type;
  } exu_bpu_upd_t;

  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    xlen_t     data;
  } exu_csr_wr_t;

endpackage

// File: source/exu_top.sv
`timescale 1ns/1ns

module exu_top #(
  parameter int MUL_BITS_PER_CYCLE = 4
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   issue_i,
  input  exu_pkg::exu_issue_t    issue_data_i,
  output exu_pkg::xlen_t         alu_data_o,
  output exu_pkg::reg_idx_t      rd_o,
  output exu_pkg::exu_csr_wr_t   csr_wr_o,
  output exu_pkg::exu_redirect_t redirect_o,
  output logic                   flush_o,
  output exu_pkg::exu_bpu_upd_t  bpu_upd_o,
  output logic                   stall_o
);
  import exu_pkg::*;

  opnd_sel_t  opnd_sel;
  jump_type_t jump_type;
  logic       mul_load;
  logic       mul_step;
  logic       mul_done;
  xlen_t      alu_a;
  xlen_t      alu_b;
  logic       cmp_true;

  exu_ctrl #(
    .MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)
  ) exu_ctrl_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .issue_i     (issue_i),
    .exc_op_i    (issue_data_i.exc_op),
    .alu_op_i    (issue_data_i.alu_op),
    .opnd_sel_o  (opnd_sel),
    .jump_type_o (jump_type),
    .mul_load_o  (mul_load),
    .mul_step_o  (mul_step),
    .mul_done_o  (mul_done),
    .stall_o     (stall_o)
  );

  exu_operand_sel exu_operand_sel_inst (
    .issue_data_i (issue_data_i),
    .opnd_sel_i   (opnd_sel),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b)
  );

  exu_alu #(
    .MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)
  ) exu_alu_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .alu_a_i    (alu_a),
    .alu_b_i    (alu_b),
    .alu_op_i   (issue_data_i.alu_op),
    .mul_load_i (mul_load),
    .mul_step_i (mul_step),
    .mul_done_i (mul_done),
    .result_o   (alu_data_o),
    .cmp_true_o (cmp_true)
  );

  exu_csr_exec exu_csr_exec_inst (
    .issue_i      (issue_i),
    .issue_data_i (issue_data_i),
    .csr_wr_o     (csr_wr_o)
  );

  exu_branch_resolve exu_branch_resolve_inst (
    .issue_i      (issue_i),
    .issue_data_i (issue_data_i),
    .jump_type_i  (jump_type),
    .cmp_true_i   (cmp_true),
    .redirect_o   (redirect_o),
    .flush_o      (flush_o),
    .bpu_upd_o    (bpu_upd_o)
  );

  assign rd_o = issue_data_i.rd;

endmodule
